// ==== files.f ====
rtl/irPkg.sv
rtl/irDecode.sv
rtl/dispatchRam.sv
rtl/irExecute.sv
rtl/irResult.sv
rtl/irBoard.sv
verif/irBoard_assert.sv
verif/irBoardTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the IR board testbench with Verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module irBoardTb -f files.f -o irBoardSim \
  && ./obj_dir/irBoardSim > sim.log 2>&1
status=$?
[ -f sim.log ] && cat sim.log
[ $status -eq 0 ] && [ -f sim.log ] && ! grep -q "Errors found" sim.log \
  && echo "PASS" && exit 0
echo "FAIL" || true
exit 1

// ==== verif/irBoardTb.sv ====
`timescale 1ns/1ps

module irBoardTb;

  logic            eboxClk, rstN, mbXfer, loadIR, loadDRAM;
  logic            diagLoadFunc06X, diagReadFunc13X;
  logic [0:35]     cacheDataRead, ebusIn;
  logic [0:8]      cramMagic;
  logic [2:0]      diagFunc;
  irPkg::edpT      edp;
  irPkg::irFieldsT ir;
  logic [9:12]     irac;
  logic            ioLegal, acEq0, jrst0, adEq0, testSatisfied;
  logic [2:0]      norm;
  irPkg::dispatchT dispatch;
  irPkg::ebusT     ebus;

  logic [31:0]     lfsr;
  int              errors, checks, tests;
  // Expected RAM contents, kept in step with every diagnostic load
  irPkg::dramWordT ramModel [0:255];

  irBoard DUT (.*);

  initial begin
    eboxClk = 1'b0;
    forever #5 eboxClk = ~eboxClk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] randomBits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // 7XX remap, AC bits forced high for the 774-777 group
  function automatic logic [0:8] dispatchAddr(logic [0:12] v, logic enIo);
    if ((&v[0:2]) && enIo) begin
      return {v[0:2], (&v[3:6]) ? 3'b111 : v[7:9], v[10:12]};
    end
    return v[0:8];
  endfunction

  function automatic logic [2:0] normCode(logic [0:35] ad);
    logic [2:0] code;
    code = 3'd0;
    if (|ad[11:35]) code = 3'd7;
    for (int k = 10; k >= 7; k--) begin
      if (ad[k]) code = 3'(k - 4);
    end
    if (|ad[1:6]) code = 3'd2;
    if (ad[0]) code = 3'd1;
    return code;
  endfunction

  task automatic checkValue(logic [63:0] got, logic [63:0] want, string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  task automatic clearStrobes();
    loadIR = 1'b0;
    loadDRAM = 1'b0;
    diagLoadFunc06X = 1'b0;
    diagReadFunc13X = 1'b0;
  endtask

  // Next edge, then drive 1 ns after it
  task automatic tick();
    @(posedge eboxClk);
    #1;
    clearStrobes();
  endtask

  task automatic finishTest(string name);
    tests++;
    $display("Test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  task automatic loadIr(logic [0:12] v, logic viaEdp);
    logic [0:22] junk;
    junk = 23'(randomBits(23));
    mbXfer = viaEdp;
    edp.ad = viaEdp ? {v, junk} : {~v, junk};
    edp.adCarryOut = 1'b0;
    cacheDataRead = viaEdp ? {~v, junk} : {v, junk};
    loadIR = 1'b1;
    tick();
    edp = '0;
    mbXfer = 1'b0;
  endtask

  task automatic diagWrite(logic [2:0] func, logic [0:35] data, logic [0:7] idx);
    diagFunc = func;
    ebusIn = data;
    diagLoadFunc06X = 1'b1;
    tick();
    case (func)
      irPkg::loadXyEven: begin
        ramModel[idx].even.a = data[0:2];
        ramModel[idx].even.b = data[3:5];
        ramModel[idx].even.p = data[6];
      end
      irPkg::loadXyOdd: begin
        ramModel[idx].odd.a = data[0:2];
        ramModel[idx].odd.b = data[3:5];
        ramModel[idx].odd.p = data[6];
      end
      irPkg::loadJCommon: ramModel[idx].jCommon = data[0:3];
      irPkg::loadJEven: ramModel[idx].even.jLow = data[0:3];
      irPkg::loadJOdd: ramModel[idx].odd.jLow = data[0:3];
      default: begin
      end
    endcase
  endtask

  // All five RAM fields at idx, B optionally pinned in both halves
  task automatic writeFields(logic [0:7] idx, logic useB, logic [0:2] bCode);
    logic [0:35] d;
    for (int f = 0; f < 5; f++) begin
      d = 36'(randomBits(36));
      if (useB && f < 2) d[3:5] = bCode;
      diagWrite(3'(f), d, idx);
    end
  endtask

  task automatic readGroup(logic [2:0] func, logic [0:5] want);
    diagFunc = func;
    diagReadFunc13X = 1'b1;
    #2;
    checkValue(64'(ebus.drive), 64'd1, "ebus drive");
    checkValue(64'(ebus.data[0:5]), 64'(want), $sformatf("ebus group %0d", func));
    tick();
  endtask

  task automatic pulseLoadDram();
    loadDRAM = 1'b1;
    tick();
    tick();
  endtask

  task automatic testResetAndLoad();
    logic [0:12] v;
    checkValue(64'(ebus.drive), 64'd0, "idle ebus drive");
    // Zero adder result gives adEq0, empty IR gives AC zero
    for (int g = 0; g < 8; g++) begin
      readGroup(3'(g), (g == 6) ? 6'b101000 : 6'b000000);
    end
    for (int i = 0; i < 10; i++) begin
      v = 13'(randomBits(13));
      if (i == 0) v = {9'o254, 4'b0000};
      if (i == 1) v = {9'o254, 4'b0101};
      loadIr(v, i[0]);
      checkValue(64'(ir), 64'(v), "ir");
      checkValue(64'(ioLegal), 64'(&v[3:6]), "ioLegal");
      checkValue(64'(acEq0), 64'(v[9:12] == 4'b0000), "acEq0");
      checkValue(64'(jrst0), 64'(v == {9'o254, 4'b0000}), "jrst0");
    end
    finishTest("reset and IR load");
  endtask

  task automatic testAcRegister();
    logic [0:12] v;
    for (int en = 1; en >= 0; en--) begin
      diagWrite(irPkg::setEnAc, {en[0], 35'd0}, 8'h00);
      for (int i = 0; i < 3; i++) begin
        v = 13'(randomBits(13));
        loadIr(v, i[0]);
        checkValue(64'(irac), en ? 64'(v[9:12]) : 64'd0, "irac");
        readGroup(3'd2, {1'b0, en[0], en ? v[9:12] : 4'b0000});
      end
    end
    finishTest("AC register");
  endtask

  task automatic testDispatchAddress();
    logic [0:12] v;
    logic [0:8]  a;
    for (int en = 0; en < 2; en++) begin
      diagWrite(irPkg::setEnIoJrst, {en[0], 35'd0}, 8'h00);
      // New flag shows on the very next read with the AC register still clear
      readGroup(3'd2, {en[0], 1'b0, 4'b0000});
      for (int i = 0; i < 6; i++) begin
        v = 13'(randomBits(13));
        if (i < 4) v[0:2] = 3'b111;
        if (i[0]) v[3:6] = 4'b1111;
        a = dispatchAddr(v, en[0]);
        loadIr(v, 1'b0);
        loadDRAM = 1'b1;
        tick();
        readGroup(3'd0, {3'b000, a[0:2]});
        readGroup(3'd1, a[3:8]);
      end
    end
    finishTest("dispatch address");
  endtask

  task automatic testDispatchFields();
    logic [0:12]       v;
    logic [0:8]        a;
    logic [7:10]       jl;
    irPkg::dramEntryT  e;
    irPkg::dispatchT   want;
    diagWrite(irPkg::setEnIoJrst, {1'b1, 35'd0}, 8'h00);
    for (int i = 0; i < 12; i++) begin
      v = 13'(randomBits(13));
      if (i % 3 == 0) v[0:8] = 9'o254;
      if (i % 3 == 1) v[0:2] = 3'b111;
      if (i == 0) v[9:12] = 4'b0000;
      a = dispatchAddr(v, 1'b1);
      loadIr(v, 1'b1);
      writeFields(a[0:7], 1'b0, 3'b000);
      pulseLoadDram();
      e = a[8] ? ramModel[a[0:7]].odd : ramModel[a[0:7]].even;
      // JRST dispatches on the AC field
      jl = (v[0:8] == 9'o254) ? v[9:12] : e.jLow;
      want.dramA = e.a;
      want.dramB = e.b;
      want.dramJ = {1'b0, ramModel[a[0:7]].jCommon, 2'b00, jl};
      want.p = e.p;
      want.oddParity = ^{e.a, e.b, e.p, ramModel[a[0:7]].jCommon, jl};
      checkValue(64'(dispatch), 64'(want), "dispatch");
      readGroup(3'd3, {e.a, e.b});
      // Adder result is zero here so only B0 and B1 decide the test
      readGroup(3'd4, {e.b[1] ^ e.b[0], v == {9'o254, 4'b0000},
                       ramModel[a[0:7]].jCommon});
      readGroup(3'd5, {e.p, want.oddParity, jl});
    end
    finishTest("dispatch fields");
  endtask

  task automatic testConditions();
    logic [0:12] v;
    logic [0:8]  a;
    logic [0:2]  bc;
    logic [0:35] ad;
    logic [0:8]  m;
    logic        co, z, ts;
    for (int b = 0; b < 8; b++) begin
      bc = 3'(b);
      v = 13'(randomBits(13));
      a = dispatchAddr(v, 1'b1);
      loadIr(v, 1'b0);
      writeFields(a[0:7], 1'b1, bc);
      pulseLoadDram();
      checkValue(64'(dispatch.dramB), 64'(bc), "dramB");
      for (int t = 0; t < 8; t++) begin
        // Random shift spreads the leading one across the norm ranges
        ad = 36'(randomBits(36)) >> randomBits(6);
        co = 1'(randomBits(1));
        m = 9'(randomBits(9));
        edp.ad = ad;
        edp.adCarryOut = co;
        cramMagic = m;
        #1;
        z = (ad == 36'd0);
        ts = (bc[1] & z) | (bc[2] & (ad[0] ^ co) & m[7]) | (bc[2] & ad[0] & m[8])
             | ((m[7] ^ m[8]) & co);
        checkValue(64'(testSatisfied), 64'(ts ^ bc[0]), "testSatisfied");
        checkValue(64'(adEq0), 64'(z), "adEq0");
        checkValue(64'(norm), 64'(normCode(ad)), "norm");
        readGroup(3'd6, {z, &v[3:6], v[9:12] == 4'b0000, 3'b000});
        readGroup(3'd0, {normCode(ad), a[0:2]});
      end
    end
    edp = '0;
    finishTest("test conditions");
  endtask

  initial begin
    lfsr = 32'hf705b40f;
    errors = 0;
    checks = 0;
    tests = 0;
    rstN = 1'b0;
    cacheDataRead = '0;
    edp = '0;
    mbXfer = 1'b0;
    cramMagic = '0;
    diagFunc = 3'd0;
    ebusIn = '0;
    clearStrobes();
    repeat (16) @(posedge eboxClk);
    #1;
    rstN = 1'b1;
    tick();
    testResetAndLoad();
    testAcRegister();
    testDispatchAddress();
    testDispatchFields();
    testConditions();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verif/irBoard_assert.sv ====
`timescale 1ns/1ps

module irBoardAssert (
  input logic            eboxClk,
  input logic            rstN,
  input logic            loadDRAM,
  input logic            diagReadFunc13X,
  input irPkg::dispatchT dispatch,
  input irPkg::ebusT     ebus
);

  // Board owns the EBUS only during its read strobe
  driveFollowsRead: assert property (@(posedge eboxClk) disable iff (!rstN)
    ebus.drive == diagReadFunc13X)
    else $error("EBUS drive does not follow the read strobe");

  // New dispatch lands on the edge after the loadDRAM edge
  dispatchHeld: assert property (@(posedge eboxClk) disable iff (!rstN)
    !$past(loadDRAM, 2) |-> $stable(dispatch))
    else $error("dispatch changed without a preceding loadDRAM");

  upperDataZero: assert property (@(posedge eboxClk) disable iff (!rstN)
    ebus.data[6:35] == '0)
    else $error("EBUS data bits 6-35 are not zero");

endmodule

bind irBoard irBoardAssert uAssert (.*);

// ==== rtl/irBoard.sv ====
`timescale 1ns/1ps

module irBoard (
  input  logic            eboxClk,
  input  logic            rstN,
  input  logic [0:35]     cacheDataRead,
  input  irPkg::edpT      edp,
  input  logic            mbXfer,
  input  logic            loadIR,
  input  logic            loadDRAM,
  input  logic [0:8]      cramMagic,
  input  logic [2:0]      diagFunc,
  input  logic            diagLoadFunc06X,
  input  logic            diagReadFunc13X,
  input  logic [0:35]     ebusIn,
  output irPkg::irFieldsT ir,
  output logic [9:12]     irac,
  output logic            ioLegal,
  output logic            acEq0,
  output logic            jrst0,
  output logic            adEq0,
  output logic            testSatisfied,
  output logic [2:0]      norm,
  output irPkg::dispatchT dispatch,
  output irPkg::ebusT     ebus
);

  irPkg::decodeStatusT status;
  irPkg::dramWordT     ramWord;
  logic [0:7]          ramIndex;
  logic                selOdd;

  irDecode uDecode (
    .eboxClk         (eboxClk),
    .rstN            (rstN),
    .cacheDataRead   (cacheDataRead),
    .edp             (edp),
    .mbXfer          (mbXfer),
    .loadIR          (loadIR),
    .loadDRAM        (loadDRAM),
    .diagFunc        (diagFunc),
    .diagLoadFunc06X (diagLoadFunc06X),
    .ebusIn          (ebusIn),
    .ir              (ir),
    .status          (status),
    .ramIndex        (ramIndex),
    .selOdd          (selOdd)
  );

  dispatchRam uRam (
    .eboxClk         (eboxClk),
    .rstN            (rstN),
    .ramIndex        (ramIndex),
    .diagFunc        (diagFunc),
    .diagLoadFunc06X (diagLoadFunc06X),
    .ebusIn          (ebusIn),
    .ramWord         (ramWord)
  );

  irExecute uExecute (
    .eboxClk       (eboxClk),
    .rstN          (rstN),
    .loadDRAM      (loadDRAM),
    .ramWord       (ramWord),
    .selOdd        (selOdd),
    .status        (status),
    .edp           (edp),
    .cramMagic     (cramMagic),
    .dispatch      (dispatch),
    .testSatisfied (testSatisfied),
    .adEq0         (adEq0),
    .norm          (norm)
  );

  irResult uResult (
    .diagReadFunc13X (diagReadFunc13X),
    .diagFunc        (diagFunc),
    .status          (status),
    .dispatch        (dispatch),
    .testSatisfied   (testSatisfied),
    .adEq0           (adEq0),
    .norm            (norm),
    .ebus            (ebus)
  );

  // Decode flags straight from the status bundle
  assign irac    = status.irac;
  assign ioLegal = status.ioLegal;
  assign acEq0   = status.acEq0;
  assign jrst0   = status.jrst0;

endmodule

// ==== rtl/irResult.sv ====
`timescale 1ns/1ps

module irResult (
  input  logic                diagReadFunc13X,
  input  logic [2:0]          diagFunc,
  input  irPkg::decodeStatusT status,
  input  irPkg::dispatchT     dispatch,
  input  logic                testSatisfied,
  input  logic                adEq0,
  input  logic [2:0]          norm,
  output irPkg::ebusT         ebus
);

  logic [0:5] group;

  // Six-bit diagnostic group per function code
  always_comb begin
    case (diagFunc)
      3'd0: begin
        group = {norm, status.dradr[0:2]};
      end
      3'd1: begin
        group = status.dradr[3:8];
      end
      3'd2: begin
        group = {status.enIoJrst, status.enAc, status.irac};
      end
      3'd3: begin
        group = {dispatch.dramA, dispatch.dramB};
      end
      3'd4: begin
        group = {testSatisfied, status.jrst0, dispatch.dramJ[1:4]};
      end
      3'd5: begin
        group = {dispatch.p, dispatch.oddParity, dispatch.dramJ[7:10]};
      end
      3'd6: begin
        // Carry taps of the real board read as zero here
        group = {adEq0, status.ioLegal, status.acEq0, 3'b000};
      end
      default: begin
        group = 6'b000000;
      end
    endcase
  end

  // Board only drives EBUS during its read strobe
  always_comb begin
    ebus.drive = diagReadFunc13X;
    ebus.data  = '0;
    if (diagReadFunc13X) begin
      ebus.data[0:5] = group;
    end
  end

endmodule

// ==== rtl/irExecute.sv ====
`timescale 1ns/1ps

module irExecute (
  input  logic                eboxClk,
  input  logic                rstN,
  input  logic                loadDRAM,
  input  irPkg::dramWordT     ramWord,
  input  logic                selOdd,
  input  irPkg::decodeStatusT status,
  input  irPkg::edpT          edp,
  input  logic [0:8]          cramMagic,
  output irPkg::dispatchT     dispatch,
  output logic                testSatisfied,
  output logic                adEq0,
  output logic [2:0]          norm
);

  logic             loadDramD;
  logic             selOddD;
  irPkg::dramEntryT entry;
  logic [7:10]      jLowSel;
  irPkg::dispatchT  dispatchNext;
  logic             aGtB;
  logic             magic7Ne8;

  // ramWord was read at the loadDRAM edge, so track the half select with it
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      loadDramD <= 1'b0;
      selOddD   <= 1'b0;
    end else begin
      loadDramD <= loadDRAM;
      selOddD   <= selOdd;
    end
  end

  assign entry = selOddD ? ramWord.odd : ramWord.even;

  // JRST dispatches on the AC field instead of the stored low J bits
  assign jLowSel = status.jrst ? status.ir[9:12] : entry.jLow;

  assign dispatchNext.dramA     = entry.a;
  assign dispatchNext.dramB     = entry.b;
  assign dispatchNext.dramJ     = {1'b0, ramWord.jCommon, 2'b00, jLowSel};
  assign dispatchNext.p         = entry.p;
  assign dispatchNext.oddParity = ^{entry.a, entry.b, entry.p, ramWord.jCommon, jLowSel};

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      dispatch <= '0;
    end else if (loadDramD) begin
      dispatch <= dispatchNext;
    end
  end

  assign adEq0     = ~|edp.ad;
  assign aGtB      = edp.ad[0] ^ edp.adCarryOut;
  assign magic7Ne8 = cramMagic[7] ^ cramMagic[8];

  // B0 inverts the sense of the skip/jump test
  assign testSatisfied = (|{dispatch.dramB[1] & adEq0,
                            dispatch.dramB[2] & aGtB & cramMagic[7],
                            dispatch.dramB[2] & edp.ad[0] & cramMagic[8],
                            magic7Ne8 & edp.adCarryOut}) ^ dispatch.dramB[0];

  // Normalize priority encoder
  always_comb begin
    if (edp.ad[0]) begin
      norm = 3'd1;
    end else if (|edp.ad[1:6]) begin
      norm = 3'd2;
    end else if (edp.ad[7]) begin
      norm = 3'd3;
    end else if (edp.ad[8]) begin
      norm = 3'd4;
    end else if (edp.ad[9]) begin
      norm = 3'd5;
    end else if (edp.ad[10]) begin
      norm = 3'd6;
    end else if (|edp.ad[11:35]) begin
      norm = 3'd7;
    end else begin
      norm = 3'd0;
    end
  end

endmodule

// ==== rtl/dispatchRam.sv ====
`timescale 1ns/1ps

module dispatchRam (
  input  logic            eboxClk,
  input  logic            rstN,
  input  logic [0:7]      ramIndex,
  input  logic [2:0]      diagFunc,
  input  logic            diagLoadFunc06X,
  input  logic [0:35]     ebusIn,
  output irPkg::dramWordT ramWord
);

  irPkg::dramWordT mem [0:255];

  // Diagnostic loads touch one field group of the addressed word
  always_ff @(posedge eboxClk) begin
    if (diagLoadFunc06X) begin
      case (diagFunc)
        irPkg::loadXyEven: begin
          mem[ramIndex].even.a <= ebusIn[0:2];
          mem[ramIndex].even.b <= ebusIn[3:5];
          mem[ramIndex].even.p <= ebusIn[6];
        end
        irPkg::loadXyOdd: begin
          mem[ramIndex].odd.a <= ebusIn[0:2];
          mem[ramIndex].odd.b <= ebusIn[3:5];
          mem[ramIndex].odd.p <= ebusIn[6];
        end
        irPkg::loadJCommon: begin
          mem[ramIndex].jCommon <= ebusIn[0:3];
        end
        irPkg::loadJEven: begin
          mem[ramIndex].even.jLow <= ebusIn[0:3];
        end
        irPkg::loadJOdd: begin
          mem[ramIndex].odd.jLow <= ebusIn[0:3];
        end
        default: begin
          // Functions 5-7 do not address the RAM
        end
      endcase
    end
  end

  // Read every cycle, old data on a same-edge write
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ramWord <= '0;
    end else begin
      ramWord <= mem[ramIndex];
    end
  end

endmodule

// ==== rtl/irDecode.sv ====
`timescale 1ns/1ps

module irDecode (
  input  logic                eboxClk,
  input  logic                rstN,
  input  logic [0:35]         cacheDataRead,
  input  irPkg::edpT          edp,
  input  logic                mbXfer,
  input  logic                loadIR,
  input  logic                loadDRAM,
  input  logic [2:0]          diagFunc,
  input  logic                diagLoadFunc06X,
  input  logic [0:35]         ebusIn,
  output irPkg::irFieldsT     ir,
  output irPkg::decodeStatusT status,
  output logic [0:7]          ramIndex,
  output logic                selOdd
);

  logic [0:12] irNext;
  logic [0:12] irBits;
  logic [9:12] irac;
  logic        enIoJrst;
  logic        enAc;
  logic [0:8]  dradr;
  logic [0:8]  addr;
  logic        instr7xx;
  logic        instr774;
  logic        jrst;

  // Data path wins over cache when the MB transfer is active
  assign irNext = mbXfer ? edp.ad[0:12] : cacheDataRead[0:12];

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ir   <= '0;
      irac <= '0;
    end else if (loadIR) begin
      ir   <= irNext;
      irac <= enAc ? irNext[9:12] : 4'b0000;
    end
  end

  // Enable flags, only written by diagnostic functions 5 and 6
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      enIoJrst <= 1'b0;
      enAc     <= 1'b0;
    end else if (diagLoadFunc06X) begin
      if (diagFunc == irPkg::setEnIoJrst) begin
        enIoJrst <= ebusIn[0];
      end
      if (diagFunc == irPkg::setEnAc) begin
        enAc <= ebusIn[0];
      end
    end
  end

  assign irBits = ir;

  // I/O class remap for 7XX opcodes
  assign instr7xx = (&irBits[0:2]) & enIoJrst;
  assign instr774 = &irBits[3:6];

  always_comb begin
    if (instr7xx) begin
      addr = {irBits[0:2], irBits[7:9] | {3{instr774}}, irBits[10:12]};
    end else begin
      addr = irBits[0:8];
    end
  end

  // RAM is addressed from the current IR, dradr keeps the loaded copy
  assign ramIndex = addr[0:7];
  assign selOdd   = addr[8];

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      dradr <= '0;
    end else if (loadDRAM) begin
      dradr <= addr;
    end
  end

  assign jrst = (ir.op == irPkg::jrstOpcode);

  assign status.dradr    = dradr;
  assign status.irac     = irac;
  assign status.enIoJrst = enIoJrst;
  assign status.enAc     = enAc;
  assign status.jrst     = jrst;
  assign status.jrst0    = jrst && (ir.ac == 4'b0000);
  assign status.ioLegal  = &ir.op[3:6];
  assign status.acEq0    = (ir.ac == 4'b0000);
  assign status.ir       = irBits[6:12];

endmodule

// ==== rtl/irPkg.sv ====
package irPkg;

  // Captured instruction, opcode and AC field
  typedef struct packed {
    logic [0:8]  op;
    logic [9:12] ac;
  } irFieldsT;

  // One dispatch half-entry, even or odd
  typedef struct packed {
    logic [0:2]  a;
    logic [0:2]  b;
    logic        p;
    logic [7:10] jLow;
  } dramEntryT;

  // Full RAM word, J bits 1-4 shared by both halves
  typedef struct packed {
    dramEntryT   even;
    dramEntryT   odd;
    logic [1:4]  jCommon;
  } dramWordT;

  // Latched dispatch result
  typedef struct packed {
    logic [0:2]  dramA;
    logic [0:2]  dramB;
    logic [0:10] dramJ;
    logic        p;
    logic        oddParity;
  } dispatchT;

  typedef struct packed {
    logic [0:8]  dradr;
    logic [9:12] irac;
    logic        enIoJrst;
    logic        enAc;
    logic        jrst;
    logic        jrst0;
    logic        ioLegal;
    logic        acEq0;
    // IR bits 6-12, the AC part feeds the JRST J substitution
    logic [6:12] ir;
  } decodeStatusT;

  typedef struct packed {
    logic [0:35] ad;
    logic        adCarryOut;
  } edpT;

  typedef struct packed {
    logic        drive;
    logic [0:35] data;
  } ebusT;

  typedef enum logic [2:0] {
    loadXyEven  = 3'd0,
    loadXyOdd   = 3'd1,
    loadJCommon = 3'd2,
    loadJEven   = 3'd3,
    loadJOdd    = 3'd4,
    setEnIoJrst = 3'd5,
    setEnAc     = 3'd6,
    unused      = 3'd7
  } diagFuncE;

  localparam logic [0:8] jrstOpcode = 9'o254;

endpackage
